//--- Bender.yml
package:
  name: rv32i_pipeline

sources:
  - logic/rv_isa_pkg.sv
  - logic/core_pkg.sv
  - logic/instruction_decoder.sv
  - logic/register_file.sv
  - logic/forwarding_unit.sv
  - logic/execute_unit.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/core_tb.sv

//--- compile.f
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/instruction_decoder.sv
logic/register_file.sv
logic/forwarding_unit.sv
logic/execute_unit.sv
logic/core_top.sv
testbench/tb_clock_gen.sv
testbench/core_tb.sv

//--- logic/core_pkg.sv
package core_pkg;

    // ------------------------------------------------------------
    // Core constants
    // ------------------------------------------------------------
    typedef logic [3:0] byte_mask_t;

    // First fetch address after reset
    localparam rv_isa_pkg::xlen_word_t RESET_ADDRESS = 32'h0000_0000;
    // ADDI x0, x0, 0
    localparam rv_isa_pkg::xlen_word_t NOP_WORD = 32'h0000_0013;
    localparam rv_isa_pkg::xlen_word_t PC_STEP = 32'd4;
    // SW always writes the full word
    localparam byte_mask_t STORE_MASK_WORD = 4'b1111;

    // ------------------------------------------------------------
    // Pipeline stage bundles
    // ------------------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::alu_op_t    alu_op;
        logic                   use_immediate;
        rv_isa_pkg::xlen_word_t immediate;
        rv_isa_pkg::reg_index_t rd;
        logic                   rd_write;
        logic                   is_store;
        rv_isa_pkg::reg_index_t rs1_index;
        rv_isa_pkg::reg_index_t rs2_index;
        logic                   rs1_used;
        logic                   rs2_used;
    } decoded_t;

    // Execute stage, operands already forwarded
    typedef struct packed {
        rv_isa_pkg::alu_op_t    alu_op;
        logic                   use_immediate;
        rv_isa_pkg::xlen_word_t immediate;
        rv_isa_pkg::reg_index_t rd;
        logic                   rd_write;
        logic                   is_store;
        rv_isa_pkg::xlen_word_t rs1_value;
        rv_isa_pkg::xlen_word_t rs2_value;
    } id_ex_t;

    typedef struct packed {
        rv_isa_pkg::xlen_word_t result;
        rv_isa_pkg::reg_index_t rd;
        logic                   rd_write;
        logic                   is_store;
        rv_isa_pkg::xlen_word_t store_address;
        rv_isa_pkg::xlen_word_t store_data;
    } ex_mem_t;

    typedef struct packed {
        rv_isa_pkg::xlen_word_t result;
        rv_isa_pkg::reg_index_t rd;
        logic                   rd_write;
    } mem_wb_t;

endpackage

//--- logic/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                   CLK,
    input  logic                   reset,
    output rv_isa_pkg::xlen_word_t instr_address,
    input  rv_isa_pkg::xlen_word_t instr_data,
    output logic                   store_strobe,
    output rv_isa_pkg::xlen_word_t store_address,
    output rv_isa_pkg::xlen_word_t store_data,
    output core_pkg::byte_mask_t   store_mask
);

    rv_isa_pkg::xlen_word_t pc_q;
    logic                   fetch_valid_q;
    rv_isa_pkg::xlen_word_t instr_decode_q;
    core_pkg::decoded_t     decoded;
    rv_isa_pkg::reg_index_t rs1_read_index;
    rv_isa_pkg::reg_index_t rs2_read_index;
    rv_isa_pkg::xlen_word_t rf_data_1;
    rv_isa_pkg::xlen_word_t rf_data_2;
    rv_isa_pkg::xlen_word_t operand_1;
    rv_isa_pkg::xlen_word_t operand_2;
    core_pkg::id_ex_t       id_ex_d;
    core_pkg::id_ex_t       id_ex_q;
    core_pkg::ex_mem_t      ex_mem_d;
    core_pkg::ex_mem_t      ex_mem_q;
    core_pkg::mem_wb_t      mem_wb_q;

    // ------------------------------------------------------------
    // Fetch
    // ------------------------------------------------------------
    // No branches, PC only steps forward
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            pc_q          <= core_pkg::RESET_ADDRESS;
            fetch_valid_q <= 1'b0;
        end
        else
        begin
            pc_q          <= pc_q + core_pkg::PC_STEP;
            fetch_valid_q <= 1'b1;
        end
    end

    assign instr_address = pc_q;

    // Word fetched during reset is dropped
    always_ff @(posedge CLK)
    begin
        if (reset || !fetch_valid_q)
            instr_decode_q <= core_pkg::NOP_WORD;
        else
            instr_decode_q <= instr_data;
    end

    // ------------------------------------------------------------
    // Decode, register read, forwarding
    // ------------------------------------------------------------
    instruction_decoder decoder_i (
        .instruction (instr_decode_q),
        .decoded     (decoded)
    );

    // Unread sources look at x0
    assign rs1_read_index = decoded.rs1_used ? decoded.rs1_index : '0;
    assign rs2_read_index = decoded.rs2_used ? decoded.rs2_index : '0;

    register_file register_file_i (
        .CLK          (CLK),
        .reset        (reset),
        .read_index_1 (rs1_read_index),
        .read_index_2 (rs2_read_index),
        .read_data_1  (rf_data_1),
        .read_data_2  (rf_data_2),
        .write_enable (mem_wb_q.rd_write),
        .write_index  (mem_wb_q.rd),
        .write_data   (mem_wb_q.result)
    );

    forwarding_unit forwarding_unit_i (
        .rs1_index (rs1_read_index),
        .rs2_index (rs2_read_index),
        .rf_data_1 (rf_data_1),
        .rf_data_2 (rf_data_2),
        .ex_result (ex_mem_d.result),
        .ex_stage  (id_ex_q),
        .mem_stage (ex_mem_q),
        .wb_stage  (mem_wb_q),
        .operand_1 (operand_1),
        .operand_2 (operand_2)
    );

    always_comb
    begin
        id_ex_d.alu_op        = decoded.alu_op;
        id_ex_d.use_immediate = decoded.use_immediate;
        id_ex_d.immediate     = decoded.immediate;
        id_ex_d.rd            = decoded.rd;
        id_ex_d.rd_write      = decoded.rd_write;
        id_ex_d.is_store      = decoded.is_store;
        id_ex_d.rs1_value     = operand_1;
        id_ex_d.rs2_value     = operand_2;
    end

    // ------------------------------------------------------------
    // Execute
    // ------------------------------------------------------------
    execute_unit execute_unit_i (
        .stage_in  (id_ex_q),
        .stage_out (ex_mem_d)
    );

    // ------------------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------------------
    // Payload follows every cycle, reset clears the control bits
    always_ff @(posedge CLK)
    begin
        id_ex_q           <= id_ex_d;
        ex_mem_q          <= ex_mem_d;
        mem_wb_q.result   <= ex_mem_q.result;
        mem_wb_q.rd       <= ex_mem_q.rd;
        mem_wb_q.rd_write <= ex_mem_q.rd_write;
        if (reset)
        begin
            id_ex_q.rd_write  <= 1'b0;
            id_ex_q.is_store  <= 1'b0;
            ex_mem_q.rd_write <= 1'b0;
            ex_mem_q.is_store <= 1'b0;
            mem_wb_q.rd_write <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Data port, driven from the memory stage
    // ------------------------------------------------------------
    assign store_strobe  = ex_mem_q.is_store;
    assign store_address = ex_mem_q.store_address;
    assign store_data    = ex_mem_q.store_data;
    assign store_mask    = ex_mem_q.is_store ? core_pkg::STORE_MASK_WORD : '0;

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  core_pkg::id_ex_t  stage_in,
    output core_pkg::ex_mem_t stage_out
);

    rv_isa_pkg::xlen_word_t operand_a;
    rv_isa_pkg::xlen_word_t operand_b;
    logic [4:0]             shamt;
    rv_isa_pkg::xlen_word_t alu_result;

    // ------------------------------------------------------------
    // Operand select
    // ------------------------------------------------------------
    assign operand_a = stage_in.rs1_value;
    assign operand_b = stage_in.use_immediate ? stage_in.immediate : stage_in.rs2_value;
    // Shifts use the low five bits only
    assign shamt = operand_b[4:0];

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    always_comb
    begin
        case (stage_in.alu_op)
            rv_isa_pkg::ALU_ADD:  alu_result = operand_a + operand_b;
            rv_isa_pkg::ALU_SUB:  alu_result = operand_a - operand_b;
            rv_isa_pkg::ALU_SLL:  alu_result = operand_a << shamt;
            // Signed compare
            rv_isa_pkg::ALU_SLT:  alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            rv_isa_pkg::ALU_SLTU: alu_result = {31'b0, operand_a < operand_b};
            rv_isa_pkg::ALU_XOR:  alu_result = operand_a ^ operand_b;
            rv_isa_pkg::ALU_SRL:  alu_result = operand_a >> shamt;
            // Arithmetic shift keeps the sign
            rv_isa_pkg::ALU_SRA:  alu_result = $signed(operand_a) >>> shamt;
            rv_isa_pkg::ALU_OR:   alu_result = operand_a | operand_b;
            rv_isa_pkg::ALU_AND:  alu_result = operand_a & operand_b;
            // LUI
            default:              alu_result = stage_in.immediate;
        endcase
    end

    // ------------------------------------------------------------
    // Memory stage bundle
    // ------------------------------------------------------------
    always_comb
    begin
        stage_out.result   = alu_result;
        stage_out.rd       = stage_in.rd;
        stage_out.rd_write = stage_in.rd_write;
        stage_out.is_store = stage_in.is_store;
        // Store address is base plus S-type offset
        stage_out.store_address = stage_in.rs1_value + stage_in.immediate;
        stage_out.store_data    = stage_in.rs2_value;
    end

endmodule

//--- logic/forwarding_unit.sv
`timescale 1ns/10ps

module forwarding_unit (
    input  rv_isa_pkg::reg_index_t rs1_index,
    input  rv_isa_pkg::reg_index_t rs2_index,
    input  rv_isa_pkg::xlen_word_t rf_data_1,
    input  rv_isa_pkg::xlen_word_t rf_data_2,
    input  rv_isa_pkg::xlen_word_t ex_result,
    input  core_pkg::id_ex_t       ex_stage,
    input  core_pkg::ex_mem_t      mem_stage,
    input  core_pkg::mem_wb_t      wb_stage,
    output rv_isa_pkg::xlen_word_t operand_1
    ,
    output rv_isa_pkg::xlen_word_t operand_2
);

    // Nearest writer wins, register file as fallback
    function automatic rv_isa_pkg::xlen_word_t pick(
        input rv_isa_pkg::reg_index_t index,
        input rv_isa_pkg::xlen_word_t rf_data
    );
        rv_isa_pkg::xlen_word_t value;
        value = rf_data;
        // x0 is never forwarded
        if (index != '0)
        begin
            // Check oldest first so newer stages override
            if (wb_stage.rd_write && (wb_stage.rd == index))
                value = wb_stage.result;
            if (mem_stage.rd_write && (mem_stage.rd == index))
                value = mem_stage.result;
            if (ex_stage.rd_write && (ex_stage.rd == index))
                value = ex_result;
        end
        return value;
    endfunction

    // One rule, both sources
    always_comb
    begin
        operand_1 = pick(rs1_index, rf_data_1);
        operand_2 = pick(rs2_index, rf_data_2);
    end

endmodule

//--- logic/instruction_decoder.sv
`timescale 1ns/10ps

module instruction_decoder (
    input  rv_isa_pkg::xlen_word_t instruction,
    output core_pkg::decoded_t     decoded
);

    rv_isa_pkg::opcode_t    opcode;
    rv_isa_pkg::funct3_t    funct3;
    rv_isa_pkg::funct7_t    funct7;
    rv_isa_pkg::xlen_word_t imm_i;
    rv_isa_pkg::xlen_word_t imm_s;
    rv_isa_pkg::xlen_word_t imm_u;

    // Shared ALU mapping for OP and OP-IMM
    // SUB exists only in register form, SRA/SRAI in both
    function automatic rv_isa_pkg::alu_op_t alu_op_of(
        input rv_isa_pkg::funct3_t f3,
        input rv_isa_pkg::funct7_t f7,
        input logic                reg_form
    );
        logic alt;
        alt = (f7 == rv_isa_pkg::F7_ALT);
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: alu_op_of = (reg_form && alt) ? rv_isa_pkg::ALU_SUB
                                                                  : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     alu_op_of = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_op_of = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    alu_op_of = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     alu_op_of = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: alu_op_of = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      alu_op_of = rv_isa_pkg::ALU_OR;
            default:                alu_op_of = rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Field split and immediates
    // ------------------------------------------------------------
    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    // I-type, sign extended
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    // S-type, split across two fields
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    // U-type, upper 20 bits
    assign imm_u = {instruction[31:12], 12'b0};

    always_comb
    begin
        // Default is a NOP bundle
        decoded           = '0;
        decoded.alu_op    = rv_isa_pkg::ALU_ADD;
        decoded.rd        = instruction[11:7];
        decoded.rs1_index = instruction[19:15];
        decoded.rs2_index = instruction[24:20];
        case (opcode)
            rv_isa_pkg::OPC_OP_IMM:
            begin
                decoded.alu_op        = alu_op_of(funct3, funct7, 1'b0);
                decoded.use_immediate = 1'b1;
                decoded.immediate     = imm_i;
                decoded.rd_write      = 1'b1;
                decoded.rs1_used      = 1'b1;
            end
            rv_isa_pkg::OPC_OP:
            begin
                decoded.alu_op   = alu_op_of(funct3, funct7, 1'b1);
                decoded.rd_write = 1'b1;
                decoded.rs1_used = 1'b1;
                decoded.rs2_used = 1'b1;
            end
            rv_isa_pkg::OPC_LUI:
            begin
                // Immediate flows through the ALU
                decoded.alu_op        = rv_isa_pkg::ALU_PASS_IMM;
                decoded.use_immediate = 1'b1;
                decoded.immediate     = imm_u;
                decoded.rd_write      = 1'b1;
            end
            rv_isa_pkg::OPC_STORE:
            begin
                // Only SW, other widths stay NOP
                if (funct3 == rv_isa_pkg::F3_SW)
                begin
                    decoded.use_immediate = 1'b1;
                    decoded.immediate     = imm_s;
                    decoded.is_store      = 1'b1;
                    decoded.rs1_used      = 1'b1;
                    decoded.rs2_used      = 1'b1;
                end
            end
            default:
            begin
                // Unsupported opcode, nothing written
                decoded.rd_write = 1'b0;
            end
        endcase
    end

endmodule

//--- logic/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                   CLK,
    input  logic                   reset,
    input  rv_isa_pkg::reg_index_t read_index_1,
    input  rv_isa_pkg::reg_index_t read_index_2,
    output rv_isa_pkg::xlen_word_t read_data_1,
    output rv_isa_pkg::xlen_word_t read_data_2,
    input  logic                   write_enable,
    input  rv_isa_pkg::reg_index_t write_index,
    input  rv_isa_pkg::xlen_word_t write_data
);

    rv_isa_pkg::xlen_word_t regs [rv_isa_pkg::REG_COUNT];

    // Synchronous write port
    // x0 never takes a write so it stays zero after reset
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < rv_isa_pkg::REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (write_enable && (write_index != '0))
        begin
            regs[write_index] <= write_data;
        end
    end

    // Combinational reads
    // Same-cycle write is covered by write-back forwarding
    assign read_data_1 = regs[read_index_1];
    assign read_data_2 = regs[read_index_2];

endmodule

//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // ------------------------------------------------------------
    // Field and word types
    // ------------------------------------------------------------
    typedef logic [31:0] xlen_word_t;
    typedef logic [4:0]  reg_index_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // Architectural register count
    localparam int REG_COUNT = 32;

    // Major opcodes handled by the core
    localparam opcode_t OPC_OP_IMM = 7'b001_0011;
    localparam opcode_t OPC_OP     = 7'b011_0011;
    localparam opcode_t OPC_LUI    = 7'b011_0111;
    localparam opcode_t OPC_STORE  = 7'b010_0011;

    // ALU groups, shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    // Word store
    localparam funct3_t F3_SW      = 3'b010;

    // Selects SUB and SRA/SRAI
    localparam funct7_t F7_ALT = 7'b010_0000;

    // Decoded ALU operation
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_IMM
    } alu_op_t;

endpackage

//--- testbench/core_tb.sv
`timescale 1ns/10ps

module core_tb;

    localparam int PROG_WORDS     = 512;
    localparam int STROBE_TIMEOUT = 100;
    localparam int RESET_TIMEOUT  = 100;
    localparam int QUIET_CYCLES   = 10;
    localparam rv_isa_pkg::xlen_word_t SEED = 32'd62;

    // Operation under test for one table row
    typedef enum logic [4:0] {
        TEST_ADD, TEST_SUB, TEST_SLL, TEST_SLT, TEST_SLTU, TEST_XOR, TEST_SRL,
        TEST_SRA, TEST_OR, TEST_AND, TEST_ADDI, TEST_SLTI, TEST_SLTIU, TEST_XORI,
        TEST_ORI, TEST_ANDI, TEST_SLLI, TEST_SRLI, TEST_SRAI, TEST_X0
    } test_op_t;

    // b doubles as the sign-extended immediate for I-type rows
    typedef struct packed {
        test_op_t               op;
        logic [1:0]             gap;
        rv_isa_pkg::xlen_word_t a;
        rv_isa_pkg::xlen_word_t b;
        rv_isa_pkg::xlen_word_t expected;
    } test_row_t;

    logic                   CLK;
    logic                   reset;
    rv_isa_pkg::xlen_word_t instr_address;
    rv_isa_pkg::xlen_word_t instr_data;
    logic                   store_strobe;
    rv_isa_pkg::xlen_word_t store_address;
    rv_isa_pkg::xlen_word_t store_data;
    core_pkg::byte_mask_t   store_mask;

    test_row_t              rows [$];
    rv_isa_pkg::xlen_word_t prog [PROG_WORDS];
    int                     prog_len;
    rv_isa_pkg::xlen_word_t rng_state;
    int                     errors;
    int                     checks;
    int                     strobe_count;
    logic                   timed_out;
    // Fetch address expected at the next falling edge
    rv_isa_pkg::xlen_word_t next_fetch;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) clock_gen_i (
        .CLK   (CLK),
        .reset (reset)
    );

    core_top dut_i (
        .CLK           (CLK),
        .reset         (reset),
        .instr_address (instr_address),
        .instr_data    (instr_data),
        .store_strobe  (store_strobe),
        .store_address (store_address),
        .store_data    (store_data),
        .store_mask    (store_mask)
    );

    // ------------------------------------------------------------
    // Instruction memory with one cycle read latency
    // ------------------------------------------------------------
    function automatic rv_isa_pkg::xlen_word_t fetch_word(input rv_isa_pkg::xlen_word_t address);
        // Past the program end the core sees NOPs
        if (address[31:2] < prog_len)
            return prog[address[31:2]];
        return core_pkg::NOP_WORD;
    endfunction

    always @(posedge CLK)
    begin
        instr_data <= fetch_word(instr_address);
    end

    // Strobe count, quiet strobe in reset and fetch address order
    // The clock falls from X at time zero, so that edge is skipped
    always @(negedge CLK)
    begin
        if ($time > 0)
        begin
            if (store_strobe === 1'b1)
                strobe_count++;
            if (reset === 1'b1 && store_strobe !== 1'b0)
            begin
                errors++;
                $display("store strobe was active during reset at %0t", $time);
            end
            // PC holds the reset address in reset and then steps by four
            check_word("instr_address", instr_address, next_fetch);
            if (reset === 1'b1)
                next_fetch = core_pkg::RESET_ADDRESS;
            else
                next_fetch = next_fetch + 32'd4;
        end
    end

    // ------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------
    function automatic rv_isa_pkg::xlen_word_t encode_i(input logic [11:0] imm,
        input rv_isa_pkg::reg_index_t rs1, input rv_isa_pkg::funct3_t f3,
        input rv_isa_pkg::reg_index_t rd);
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_isa_pkg::xlen_word_t encode_u(input logic [19:0] upper,
        input rv_isa_pkg::reg_index_t rd);
        return {upper, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    // Always x3 = x1 op x2
    function automatic rv_isa_pkg::xlen_word_t encode_r(input rv_isa_pkg::funct7_t f7,
        input rv_isa_pkg::funct3_t f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, rv_isa_pkg::OPC_OP};
    endfunction

    // SW rs2, offset(x0)
    function automatic rv_isa_pkg::xlen_word_t encode_s(input logic [11:0] offset,
        input rv_isa_pkg::reg_index_t rs2);
        return {offset[11:5], rs2, 5'd0, rv_isa_pkg::F3_SW, offset[4:0], rv_isa_pkg::OPC_STORE};
    endfunction

    function automatic rv_isa_pkg::xlen_word_t op_word(input test_op_t op, input logic [11:0] imm);
        case (op)
            TEST_ADD:   return encode_r(7'b0, rv_isa_pkg::F3_ADD_SUB);
            TEST_SUB:   return encode_r(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB);
            TEST_SLL:   return encode_r(7'b0, rv_isa_pkg::F3_SLL);
            TEST_SLT:   return encode_r(7'b0, rv_isa_pkg::F3_SLT);
            TEST_SLTU:  return encode_r(7'b0, rv_isa_pkg::F3_SLTU);
            TEST_XOR:   return encode_r(7'b0, rv_isa_pkg::F3_XOR);
            TEST_SRL:   return encode_r(7'b0, rv_isa_pkg::F3_SRL_SRA);
            TEST_SRA:   return encode_r(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SRL_SRA);
            TEST_OR:    return encode_r(7'b0, rv_isa_pkg::F3_OR);
            TEST_AND:   return encode_r(7'b0, rv_isa_pkg::F3_AND);
            TEST_ADDI:  return encode_i(imm, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd3);
            TEST_SLTI:  return encode_i(imm, 5'd1, rv_isa_pkg::F3_SLT, 5'd3);
            TEST_SLTIU: return encode_i(imm, 5'd1, rv_isa_pkg::F3_SLTU, 5'd3);
            TEST_XORI:  return encode_i(imm, 5'd1, rv_isa_pkg::F3_XOR, 5'd3);
            TEST_ORI:   return encode_i(imm, 5'd1, rv_isa_pkg::F3_OR, 5'd3);
            TEST_ANDI:  return encode_i(imm, 5'd1, rv_isa_pkg::F3_AND, 5'd3);
            // Shift immediates carry funct7 in the upper imm bits
            TEST_SLLI:  return encode_i({7'b0, imm[4:0]}, 5'd1, rv_isa_pkg::F3_SLL, 5'd3);
            TEST_SRLI:  return encode_i({7'b0, imm[4:0]}, 5'd1, rv_isa_pkg::F3_SRL_SRA, 5'd3);
            TEST_SRAI:  return encode_i({rv_isa_pkg::F7_ALT, imm[4:0]}, 5'd1,
                                        rv_isa_pkg::F3_SRL_SRA, 5'd3);
            default:    return core_pkg::NOP_WORD;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Program builder
    // ------------------------------------------------------------
    task automatic emit(input rv_isa_pkg::xlen_word_t word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // LUI then ADDI with the upper part rounded for the signed low part
    task automatic emit_load(input rv_isa_pkg::reg_index_t rd, input rv_isa_pkg::xlen_word_t value);
        rv_isa_pkg::xlen_word_t upper;
        upper = value + 32'h0000_0800;
        emit(encode_u(upper[31:12], rd));
        emit(encode_i(value[11:0], rd, rv_isa_pkg::F3_ADD_SUB, rd));
    endtask

    task automatic emit_fragment(input test_row_t row, input int index);
        rv_isa_pkg::xlen_word_t offset;
        offset = index * 4;
        if (row.op == TEST_X0)
        begin
            // Writes to x0 must not stick
            emit_load(5'd0, row.a);
            emit(encode_s(offset[11:0], 5'd0));
        end
        else
        begin
            emit_load(5'd1, row.a);
            emit_load(5'd2, row.b);
            // NOPs push the sources to older stages
            repeat (row.gap) emit(core_pkg::NOP_WORD);
            emit(op_word(row.op, row.b[11:0]));
            emit(encode_s(offset[11:0], 5'd3));
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    function automatic rv_isa_pkg::xlen_word_t xorshift32(input rv_isa_pkg::xlen_word_t x);
        rv_isa_pkg::xlen_word_t v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic draw(output rv_isa_pkg::xlen_word_t value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    task automatic add_row(input test_op_t op, input int gap, input rv_isa_pkg::xlen_word_t a,
        input rv_isa_pkg::xlen_word_t b, input rv_isa_pkg::xlen_word_t expected);
        test_row_t row;
        row.op       = op;
        row.gap      = gap[1:0];
        row.a        = a;
        row.b        = b;
        row.expected = expected;
        rows.push_back(row);
    endtask

    task automatic fill_table();
        rv_isa_pkg::xlen_word_t ra;
        rv_isa_pkg::xlen_word_t rb;
        // Register-register
        add_row(TEST_ADD,   0, 32'h1234_5678, 32'h1111_1111, 32'h2345_6789);
        add_row(TEST_SUB,   0, 32'h0000_0001, 32'h0000_0002, 32'hFFFF_FFFF);
        add_row(TEST_SLL,   0, 32'h0000_0003, 32'h0000_0024, 32'h0000_0030);
        add_row(TEST_SLT,   0, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001);
        add_row(TEST_SLTU,  0, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
        add_row(TEST_XOR,   0, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 32'hFF00_FF00);
        add_row(TEST_SRL,   0, 32'h8000_0000, 32'h0000_001F, 32'h0000_0001);
        add_row(TEST_SRA,   0, 32'h8000_0000, 32'h0000_0004, 32'hF800_0000);
        add_row(TEST_OR,    0, 32'h0000_F000, 32'h0000_0F0F, 32'h0000_FF0F);
        add_row(TEST_AND,   0, 32'hDEAD_BEEF, 32'h0000_FFFF, 32'h0000_BEEF);
        // Register-immediate with sign-extended negative immediates
        add_row(TEST_ADDI,  0, 32'h0000_0010, 32'hFFFF_FFF0, 32'h0000_0000);
        add_row(TEST_SLTI,  0, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 32'h0000_0001);
        add_row(TEST_SLTIU, 0, 32'h0000_0005, 32'hFFFF_FFFF, 32'h0000_0001);
        add_row(TEST_XORI,  0, 32'h1234_5678, 32'hFFFF_F800, 32'hEDCB_AE78);
        add_row(TEST_ORI,   0, 32'h0001_0000, 32'h0000_07FF, 32'h0001_07FF);
        add_row(TEST_ANDI,  0, 32'hFFFF_ABCD, 32'hFFFF_FF0F, 32'hFFFF_AB0D);
        add_row(TEST_SLLI,  0, 32'h0000_0001, 32'h0000_001F, 32'h8000_0000);
        add_row(TEST_SRLI,  0, 32'hF000_0000, 32'h0000_001C, 32'h0000_000F);
        add_row(TEST_SRAI,  0, 32'h8000_0010, 32'h0000_0004, 32'hF800_0001);
        // Older sources down to the register file
        add_row(TEST_ADD,   1, 32'h0000_0800, 32'h0000_07FF, 32'h0000_0FFF);
        add_row(TEST_SUB,   2, 32'h1000_0000, 32'h0000_0001, 32'h0FFF_FFFF);
        add_row(TEST_XOR,   3, 32'hAAAA_AAAA, 32'h5555_5555, 32'hFFFF_FFFF);
        add_row(TEST_X0,    0, 32'h1234_5678, 32'h0000_0000, 32'h0000_0000);
        // Random operands
        draw(ra);
        draw(rb);
        add_row(TEST_ADD, 0, ra, rb, ra + rb);
        draw(ra);
        draw(rb);
        add_row(TEST_SUB, 1, ra, rb, ra - rb);
        draw(ra);
        draw(rb);
        add_row(TEST_XOR, 2, ra, rb, ra ^ rb);
        draw(ra);
        draw(rb);
        add_row(TEST_AND, 3, ra, rb, ra & rb);
    endtask

    // ------------------------------------------------------------
    // Checks and waits
    // ------------------------------------------------------------
    task automatic check_word(input string name, input rv_isa_pkg::xlen_word_t got,
        input rv_isa_pkg::xlen_word_t expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("error at %0t: %s is %08h, expected %08h", $time, name, got, expected);
        end
    endtask

    task automatic wait_for_strobe(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < STROBE_TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
            if (store_strobe === 1'b1)
                seen = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial
    begin
        logic     seen;
        int       cycles;
        int       row_errors;
        test_op_t op_now;
        instr_data   = core_pkg::NOP_WORD;
        errors       = 0;
        checks       = 0;
        strobe_count = 0;
        timed_out    = 1'b0;
        next_fetch   = core_pkg::RESET_ADDRESS;
        rng_state    = SEED;
        prog_len     = 0;
        fill_table();
        for (int i = 0; i < PROG_WORDS; i++)
            prog[i] = core_pkg::NOP_WORD;
        for (int i = 0; i < rows.size(); i++)
            emit_fragment(rows[i], i);

        cycles = 0;
        while (reset !== 1'b0 && cycles < RESET_TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (reset !== 1'b0)
        begin
            timed_out = 1'b1;
            errors++;
            $display("reset was never released");
        end

        // One SW per row in program order
        for (int i = 0; i < rows.size() && !timed_out; i++)
        begin
            row_errors = errors;
            op_now     = rows[i].op;
            wait_for_strobe(seen);
            if (!seen)
            begin
                timed_out = 1'b1;
                errors++;
                $display("no store strobe for row %0d within %0d cycles", i, STROBE_TIMEOUT);
            end
            else
            begin
                check_word("store_address", store_address, i * 4);
                check_word("store_data", store_data, rows[i].expected);
                check_word("store_mask", {28'b0, store_mask}, 32'h0000_000F);
                $display("row %0d %s gap %0d: %s", i, op_now.name(), rows[i].gap,
                         (errors == row_errors) ? "ok" : "wrong");
            end
        end

        // Trailing NOPs must not strobe
        repeat (QUIET_CYCLES) @(negedge CLK);
        if (!timed_out && strobe_count != rows.size())
        begin
            errors++;
            $display("saw %0d store strobes but the program has %0d stores",
                     strobe_count, rows.size());
        end

        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0 && !timed_out)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic CLK,
    output logic reset
);

    // Free-running clock, starts low
    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // Reset held for a fixed count of cycles, released on a rising edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        reset <= 1'b0;
    end

endmodule
